/* verilog/dmaPkg.sv */
package dmaPkg;

  // four channels as on the 8237
  localparam int numChan = 4;

  // data, address and count widths
  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;
  typedef logic [15:0] countT;
  typedef logic [1:0]  chanT;
  typedef logic [3:0]  regAddrT;

  // cpu register map
  // addresses 0 to 7 select address (even) or count (odd) of channel addr/2
  // a read of address 8 returns the status register
  localparam regAddrT regCommand     = 4'd8;
  localparam regAddrT regMaskSingle  = 4'd10;
  localparam regAddrT regMode        = 4'd11;
  localparam regAddrT regClearFf     = 4'd12;
  localparam regAddrT regMasterClear = 4'd13;

  // transfer types, 00 and 11 both behave as verify
  localparam logic [1:0] xferWrite = 2'b01;
  localparam logic [1:0] xferRead  = 2'b10;

  // command byte, bit positions follow the 8237
  typedef struct packed {
    logic [2:0] spareHi;
    logic       rotatePri;
    logic       spareMid;
    logic       ctrlDisable;
    logic [1:0] spareLo;
  } commandT;

  // per-channel mode, taken from bits 5:2 of the mode byte
  typedef struct packed {
    logic       addrDec;
    logic       autoInit;
    logic [1:0] xferType;
  } modeT;

  // one byte written to a channel address or count register
  typedef struct packed {
    logic valid;
    chanT chan;
    logic isCount;
    logic highByte;
    byteT data;
  } cpuWriteT;

  // end of one single transfer
  typedef struct packed {
    logic valid;
    chanT chan;
  } serviceT;

  // count rolled over from zero
  typedef struct packed {
    logic valid;
    chanT chan;
    logic reloaded;
  } tcEventT;

  // timing states, S3 is not used
  typedef enum logic [2:0] {SI, SO, S1, S2, S4} timingStateT;

endpackage

/* verilog/dmaCpuPort.sv */
`timescale 1ns/1ps

module dmaCpuPort import dmaPkg::*; (
  input  logic               busIf,
  input  logic               rstN,
  input  logic               csN,
  input  logic               iorN,
  input  logic               iowN,
  input  regAddrT            regAddr,
  input  byteT               dbIn,
  input  logic [numChan-1:0] dreq,
  input  addrT               curAddr [numChan],
  input  countT              curCount [numChan],
  input  tcEventT            tcEvent,
  output byteT               dbOut,
  output cpuWriteT           chanWrite,
  output commandT            command,
  output modeT               mode [numChan],
  output logic [numChan-1:0] mask
);

  // single-cycle cpu strobes
  logic cpuWr;
  logic cpuRd;
  // addresses 0 to 7 hit the channel registers
  logic chanSel;
  chanT selChan;
  // byte pointer flip-flop, low byte while clear
  logic bytePtr;
  // tc bits of the status register
  logic [numChan-1:0] tcBits;
  byteT rdData;

  assign cpuWr   = !csN && !iowN;
  assign cpuRd   = !csN && !iorN;
  assign chanSel = !regAddr[3];
  assign selChan = regAddr[2:1];

  // write strobe to the channel register file
  always_comb begin
    chanWrite.valid    = cpuWr && chanSel;
    chanWrite.chan     = selChan;
    chanWrite.isCount  = regAddr[0];
    chanWrite.highByte = bytePtr;
    chanWrite.data     = dbIn;
  end

  // readback mux, byte picked by the flip-flop
  always_comb begin
    rdData = '0;
    if (chanSel) begin
      if (regAddr[0]) begin
        rdData = bytePtr ? curCount[selChan][15:8] : curCount[selChan][7:0];
      end else begin
        rdData = bytePtr ? curAddr[selChan][15:8] : curAddr[selChan][7:0];
      end
    end else if (regAddr == regCommand) begin
      // status: requests high nibble, tc low nibble
      rdData = {dreq, tcBits};
    end
  end

  // data only while the cpu reads
  assign dbOut = cpuRd ? rdData : '0;

  always_ff @(posedge busIf or negedge rstN) begin
    if (!rstN) begin
      command <= '0;
      mask    <= '1;
      tcBits  <= '0;
      bytePtr <= 1'b0;
      for (int i = 0; i < numChan; i++) begin
        mode[i] <= '0;
      end
    end else begin
      // read side effects
      if (cpuRd) begin
        if (chanSel) begin
          bytePtr <= !bytePtr;
        end else if (regAddr == regCommand) begin
          tcBits <= '0;
        end
      end
      // terminal count sets tc, and masks unless auto-init reloaded it
      if (tcEvent.valid) begin
        tcBits[tcEvent.chan] <= 1'b1;
        if (!tcEvent.reloaded) begin
          mask[tcEvent.chan] <= 1'b1;
        end
      end
      // cpu writes come last so a mask write wins over tc masking
      if (cpuWr) begin
        if (chanSel) begin
          bytePtr <= !bytePtr;
        end else begin
          case (regAddr)
            regCommand:    command <= commandT'(dbIn);
            // bits 1:0 pick the channel, bit 2 is the mask value
            regMaskSingle: mask[dbIn[1:0]] <= dbIn[2];
            regMode:       mode[dbIn[1:0]] <= modeT'(dbIn[5:2]);
            regClearFf:    bytePtr <= 1'b0;
            regMasterClear: begin
              // Same state as a hardware reset, channel registers kept.
              command <= '0;
              mask    <= '1;
              tcBits  <= '0;
              bytePtr <= 1'b0;
              for (int i = 0; i < numChan; i++) begin
                mode[i] <= '0;
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

/* verilog/dmaChannelRegs.sv */
`timescale 1ns/1ps

module dmaChannelRegs import dmaPkg::*; (
  input  logic     busIf,
  input  logic     rstN,
  input  cpuWriteT chanWrite,
  input  serviceT  service,
  input  modeT     mode [numChan],
  output addrT     curAddr [numChan],
  output countT    curCount [numChan],
  output tcEventT  tcEvent
);

  // base registers keep the programmed values for auto-init
  addrT  baseAddr [numChan];
  countT baseCount [numChan];
  // served channel and its stepped address
  chanT  svcChan;
  addrT  nextAddr;
  logic  atTc;
  logic  doReload;
  // channel hit by the cpu write
  chanT  wrChan;

  assign svcChan = service.chan;
  assign wrChan  = chanWrite.chan;

  // count is zero now, so this step rolls it to all ones
  assign atTc     = curCount[svcChan] == '0;
  assign doReload = atTc && mode[svcChan].autoInit;

  // decrement or increment by mode
  assign nextAddr = mode[svcChan].addrDec ? curAddr[svcChan] - 16'd1
                                          : curAddr[svcChan] + 16'd1;

  // tc is reported in the same cycle as the step
  always_comb begin
    tcEvent.valid    = service.valid && atTc;
    tcEvent.chan     = svcChan;
    tcEvent.reloaded = mode[svcChan].autoInit;
  end

  always_ff @(posedge busIf or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numChan; i++) begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
      end
    end else begin
      // step after each transfer
      if (service.valid) begin
        if (doReload) begin
          curAddr[svcChan]  <= baseAddr[svcChan];
          curCount[svcChan] <= baseCount[svcChan];
        end else begin
          curAddr[svcChan]  <= nextAddr;
          curCount[svcChan] <= curCount[svcChan] - 16'd1;
        end
      end
      // cpu load, base and current together, one byte at a time
      if (chanWrite.valid) begin
        if (chanWrite.isCount) begin
          if (chanWrite.highByte) begin
            baseCount[wrChan][15:8] <= chanWrite.data;
            curCount[wrChan][15:8]  <= chanWrite.data;
          end else begin
            baseCount[wrChan][7:0] <= chanWrite.data;
            curCount[wrChan][7:0]  <= chanWrite.data;
          end
        end else begin
          if (chanWrite.highByte) begin
            baseAddr[wrChan][15:8] <= chanWrite.data;
            curAddr[wrChan][15:8]  <= chanWrite.data;
          end else begin
            baseAddr[wrChan][7:0] <= chanWrite.data;
            curAddr[wrChan][7:0]  <= chanWrite.data;
          end
        end
      end
    end
  end

endmodule

/* verilog/dmaPriority.sv */
`timescale 1ns/1ps

module dmaPriority import dmaPkg::*; (
  input  logic               busIf,
  input  logic               rstN,
  input  logic [numChan-1:0] dreq,
  input  logic [numChan-1:0] mask,
  input  commandT            command,
  input  serviceT            service,
  output logic [numChan-1:0] grant
);

  // requests that may be served
  logic [numChan-1:0] active;
  // highest priority channel under rotation
  chanT topChan;
  // search start, channel 0 in fixed mode
  chanT startChan;
  chanT idx;
  logic found;

  assign active    = dreq & ~mask & {numChan{!command.ctrlDisable}};
  assign startChan = command.rotatePri ? topChan : '0;

  // walk upward from startChan, first active request wins
  always_comb begin
    grant = '0;
    found = 1'b0;
    idx   = startChan;
    for (int i = 0; i < numChan; i++) begin
      idx = startChan + chanT'(i);
      if (!found && active[idx]) begin
        grant[idx] = 1'b1;
        found      = 1'b1;
      end
    end
  end

  // after a service the next channel up becomes highest priority
  always_ff @(posedge busIf or negedge rstN) begin
    if (!rstN) begin
      topChan <= '0;
    end else if (service.valid && command.rotatePri) begin
      topChan <= service.chan + 2'd1;
    end
  end

endmodule

/* verilog/dmaTiming.sv */
`timescale 1ns/1ps

module dmaTiming import dmaPkg::*; (
  input  logic               busIf,
  input  logic               rstN,
  input  logic [numChan-1:0] grant,
  input  logic               hlda,
  input  logic               eopN,
  input  modeT               mode [numChan],
  input  addrT               curAddr [numChan],
  input  tcEventT            tcEvent,
  output logic               hrq,
  output logic               aen,
  output logic               adstb,
  output addrT               addrOut,
  output logic [numChan-1:0] dack,
  output logic               dmaIorN,
  output logic               dmaIowN,
  output logic               memrN,
  output logic               memwN,
  output logic               eopOut,
  output serviceT            service
);

  timingStateT state;
  timingStateT nextState;
  // granted channel as an index
  chanT grantChan;
  // channel and type latched for the running transfer
  chanT curChan;
  logic [1:0] curType;
  // active bus cycle, S1 through S4
  logic inCycle;
  logic isWrite;
  logic isRead;

  // one-hot grant to index
  always_comb begin
    grantChan = '0;
    for (int i = 0; i < numChan; i++) begin
      if (grant[i]) begin
        grantChan = chanT'(i);
      end
    end
  end

  // eopN aborts anywhere past SI
  always_comb begin
    nextState = state;
    case (state)
      SI: begin
        if (|grant) begin
          nextState = SO;
        end
      end
      SO: begin
        // wait here for hold acknowledge
        if (!eopN) begin
          nextState = SI;
        end else if (hlda) begin
          nextState = S1;
        end
      end
      S1:      nextState = eopN ? S2 : SI;
      S2:      nextState = eopN ? S4 : SI;
      S4:      nextState = SI;
      default: nextState = SI;
    endcase
  end

  always_ff @(posedge busIf or negedge rstN) begin
    if (!rstN) begin
      state   <= SI;
      curChan <= '0;
      curType <= '0;
      eopOut  <= 1'b0;
    end else begin
      state <= nextState;
      // latch the winner while idle, each transfer re-arbitrates
      if (state == SI && |grant) begin
        curChan <= grantChan;
        curType <= mode[grantChan].xferType;
      end
      // tc pulse lands in the cycle after S4
      eopOut <= tcEvent.valid;
    end
  end

  assign inCycle = (state == S1) || (state == S2) || (state == S4);
  assign isWrite = curType == xferWrite;
  assign isRead  = curType == xferRead;

  // hold request from SO until the return to SI
  assign hrq     = state != SI;
  assign aen     = inCycle;
  assign adstb   = state == S1;
  assign addrOut = inCycle ? curAddr[curChan] : '0;

  always_comb begin
    for (int i = 0; i < numChan; i++) begin
      dack[i] = inCycle && (curChan == chanT'(i));
    end
  end

  // write transfer moves io to memory, read transfer memory to io
  // verify drives no strobes at all
  assign dmaIorN = !(state == S2 && isWrite);
  assign memrN   = !(state == S2 && isRead);
  assign memwN   = !(state == S4 && isWrite);
  assign dmaIowN = !(state == S4 && isRead);

  // no step if the cycle was cut short by eopN
  always_comb begin
    service.valid = (state == S4) && eopN;
    service.chan  = curChan;
  end

endmodule

/* verilog/dmaTop.sv */
`timescale 1ns/1ps

module dmaTop import dmaPkg::*; (
  input  logic               busIf,
  input  logic               rstN,
  // cpu programming port
  input  logic               csN,
  input  logic               iorN,
  input  logic               iowN,
  input  regAddrT            regAddr,
  input  byteT               dbIn,
  output byteT               dbOut,
  // requests and hold handshake
  input  logic [numChan-1:0] dreq,
  input  logic               hlda,
  input  logic               eopN,
  output logic               hrq,
  // transfer bus
  output logic               aen,
  output logic               adstb,
  output addrT               addrOut,
  output logic [numChan-1:0] dack,
  output logic               dmaIorN,
  output logic               dmaIowN,
  output logic               memrN,
  output logic               memwN,
  output logic               eopOut
);

  // internal nets share the port names of the blocks
  cpuWriteT           chanWrite;
  commandT            command;
  modeT               mode [numChan];
  logic [numChan-1:0] mask;
  addrT               curAddr [numChan];
  countT              curCount [numChan];
  tcEventT            tcEvent;
  logic [numChan-1:0] grant;
  serviceT            service;

  dmaCpuPort     uCpuPort (.*);
  dmaChannelRegs uChannelRegs (.*);
  dmaPriority    uPriority (.*);
  dmaTiming      uTiming (.*);

endmodule

/* verification/dmaTb.sv */
`timescale 1ns/1ps

module dmaTb import dmaPkg::*; ();

  // planned transfers that size the watchdog
  localparam int plannedXfers = 30;

  // what the model expects for the next bus cycle
  typedef struct packed {
    logic valid;
    chanT chan;
    addrT addr;
  } expT;

  logic busIf = 1'b0;
  logic rstN;
  logic csN;
  logic iorN;
  logic iowN;
  regAddrT regAddr;
  byteT dbIn;
  byteT dbOut;
  logic [numChan-1:0] dreq;
  logic hlda;
  logic eopN;
  logic hrq;
  logic aen;
  logic adstb;
  addrT addrOut;
  logic [numChan-1:0] dack;
  logic dmaIorN;
  logic dmaIowN;
  logic memrN;
  logic memwN;
  logic eopOut;

  // reference model state
  addrT mAddr [numChan];
  addrT mBaseA [numChan];
  countT mCount [numChan];
  countT mBaseC [numChan];
  modeT mMode [numChan];
  logic [numChan-1:0] mMask = '1;
  logic [numChan-1:0] mTc = '0;
  chanT mTop = '0;
  byteT mCmd = '0;

  // checker bookkeeping
  logic [numChan-1:0] dreqSeen;
  logic hrqPrev = 1'b0;
  logic eopNext = 1'b0;
  expT pend = '0;
  int cyc = 0;
  int xferDone = 0;
  // dack seen in each S4
  logic [numChan-1:0] servedQ [$];
  logic [1:0] xType;

  int errors = 0;
  int testErrBase = 0;
  int testsRun = 0;
  string testName = "none";
  logic [31:0] rndState = 32'hf220;
  logic [15:0] word;
  addrT abortAddr;
  logic ai;
  logic dec;
  logic [1:0] ty;

  dmaTop dut (.*);

  always #10 busIf = !busIf;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // predicts which channel wins and the address it puts on the bus
  function automatic expT refDma(input logic [numChan-1:0] req);
    expT r;
    logic [numChan-1:0] act;
    chanT c;
    r = '0;
    // bit 2 disables the controller and bit 4 selects rotation
    act = req & ~mMask & {numChan{!mCmd[2]}};
    for (int i = 0; i < numChan; i++) begin
      c = (mCmd[4] ? mTop : 2'd0) + chanT'(i);
      if (!r.valid && act[c]) begin
        r.valid = 1'b1;
        r.chan = c;
        r.addr = mAddr[c];
      end
    end
    return r;
  endfunction

  // model of one finished single transfer
  function automatic void refStep(input chanT c);
    if (mCount[c] == '0) begin
      mTc[c] = 1'b1;
      if (!mMode[c].autoInit) begin
        mMask[c] = 1'b1;
      end
    end
    if (mCount[c] == '0 && mMode[c].autoInit) begin
      mAddr[c] = mBaseA[c];
      mCount[c] = mBaseC[c];
    end else begin
      mAddr[c] = mMode[c].addrDec ? mAddr[c] - 16'd1 : mAddr[c] + 16'd1;
      mCount[c] = mCount[c] - 16'd1;
    end
    if (mCmd[4]) begin
      mTop = c + 2'd1;
    end
  endfunction

  task automatic checkVal(input string what, input logic [31:0] expV, input logic [31:0] actV);
    assert (expV === actV) else begin
      $display("CHECK FAILED %s %s expected %h actual %h", testName, what, expV, actV);
      errors++;
    end
  endtask

  task automatic cpuWrite(input regAddrT a, input byteT d);
    @(negedge busIf);
    csN = 1'b0;
    iowN = 1'b0;
    regAddr = a;
    dbIn = d;
    @(negedge busIf);
    csN = 1'b1;
    iowN = 1'b1;
  endtask

  // dbOut is sampled mid low phase
  task automatic cpuRead(input regAddrT a, output byteT d);
    @(negedge busIf);
    csN = 1'b0;
    iorN = 1'b0;
    regAddr = a;
    #5;
    d = dbOut;
    @(negedge busIf);
    csN = 1'b1;
    iorN = 1'b1;
  endtask

  task automatic readWord(input regAddrT a, output logic [15:0] w);
    byteT lo;
    byteT hi;
    cpuWrite(regClearFf, 8'h00);
    cpuRead(a, lo);
    cpuRead(a, hi);
    w = {hi, lo};
  endtask

  // reading status clears the tc bits
  task automatic readStatus();
    byteT s;
    cpuRead(regCommand, s);
    checkVal("status tc", mTc, s[3:0]);
    mTc = '0;
  endtask

  task automatic programChan(input chanT c, input addrT a, input countT n);
    cpuWrite(regClearFf, 8'h00);
    cpuWrite({1'b0, c, 1'b0}, a[7:0]);
    cpuWrite({1'b0, c, 1'b0}, a[15:8]);
    cpuWrite({1'b0, c, 1'b1}, n[7:0]);
    cpuWrite({1'b0, c, 1'b1}, n[15:8]);
    mAddr[c] = a;
    mBaseA[c] = a;
    mCount[c] = n;
    mBaseC[c] = n;
  endtask

  // mode byte holds single mode, dec, auto-init, type and channel
  task automatic setMode(input chanT c, input logic [1:0] t, input logic a, input logic d);
    cpuWrite(regMode, {2'b01, d, a, t, c});
    mMode[c] = {d, a, t};
  endtask

  task automatic setMask(input chanT c, input logic v);
    cpuWrite(regMaskSingle, {5'b0, v, c});
    mMask[c] = v;
  endtask

  task automatic setCommand(input byteT v);
    cpuWrite(regCommand, v);
    mCmd = v;
  endtask

  task automatic waitXfers(input int n);
    int target;
    target = xferDone + n;
    wait (xferDone >= target);
  endtask

  task automatic waitIdle();
    @(negedge busIf);
    while (hrq) begin
      @(negedge busIf);
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrBase = errors;
  endtask

  task automatic endTest();
    $display("test %-10s %s, %0d errors", testName,
             (errors == testErrBase) ? "ok" : "failed", errors - testErrBase);
    testsRun++;
  endtask

  // hold acknowledge after a random wait of 0 to 7 cycles
  initial begin
    hlda = 1'b0;
    forever begin
      @(negedge busIf);
      if (!hrq) begin
        hlda = 1'b0;
      end else if (!hlda) begin
        rndState = xorshift(rndState);
        repeat (rndState[2:0]) @(negedge busIf);
        hlda = 1'b1;
      end
    end
  end

  // request lines as the DUT saw them at the last edge
  always @(posedge busIf) begin
    dreqSeen <= dreq;
  end

  // compare each bus cycle with the model
  always @(negedge busIf) begin
    if (rstN) begin
      checkVal("eopOut", eopNext, eopOut);
      eopNext = 1'b0;
      if (hrq && !hrqPrev) begin
        pend = refDma(dreqSeen);
        assert (pend.valid) else begin
          $display("%s: hold request raised with no unmasked request pending", testName);
          errors++;
        end
      end
      xType = mMode[pend.chan].xferType;
      if (adstb) begin
        cyc = 1;
        checkVal("dack", 4'b0001 << pend.chan, dack);
        checkVal("address", pend.addr, addrOut);
      end else if (aen) begin
        cyc++;
        if (cyc == 2) begin
          checkVal("S2 strobes", {xType != xferWrite, xType != xferRead, 2'b11},
                   {dmaIorN, memrN, dmaIowN, memwN});
        end
        if (cyc == 3) begin
          checkVal("S4 strobes", {2'b11, xType != xferRead, xType != xferWrite},
                   {dmaIorN, memrN, dmaIowN, memwN});
          // eopOut follows in the next cycle when the count ran out
          eopNext = mCount[pend.chan] == '0;
          servedQ.push_back(dack);
          refStep(pend.chan);
          xferDone++;
        end
      end
    end
    hrqPrev = hrq;
  end

  initial begin
    #((plannedXfers * 20 + 600) * 20);
    $display("timeout: the DUT did not finish the planned transfers in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    regAddr = '0;
    dbIn = '0;
    dreq = '0;
    eopN = 1'b1;
    repeat (4) @(posedge busIf);
    @(negedge busIf);
    rstN = 1'b1;

    startTest("reset");
    checkVal("idle pins", 12'h00f,
             {hrq, aen, adstb, dack, eopOut, dmaIorN, dmaIowN, memrN, memwN});
    readStatus();
    endTest();

    startTest("program");
    for (int c = 0; c < numChan; c++) begin
      rndState = xorshift(rndState);
      programChan(chanT'(c), rndState[15:0], rndState[31:16]);
    end
    for (int c = 0; c < numChan; c++) begin
      readWord({1'b0, chanT'(c), 1'b0}, word);
      checkVal("address readback", mAddr[c], word);
      readWord({1'b0, chanT'(c), 1'b1}, word);
      checkVal("count readback", mCount[c], word);
    end
    endTest();

    // channel 0 stays masked
    startTest("fixed");
    setCommand(8'h00);
    for (int c = 0; c < numChan; c++) begin
      programChan(chanT'(c), 16'h1000 * (c + 1), 16'd40);
      setMode(chanT'(c), xferWrite, 1'b0, 1'b0);
      setMask(chanT'(c), c == 0);
    end
    dreq = 4'b1111;
    waitXfers(3);
    dreq = 4'b0000;
    waitIdle();
    dreq = 4'b1100;
    waitXfers(3);
    dreq = 4'b0000;
    waitIdle();
    // only the masked channel asks
    dreq = 4'b0001;
    repeat (20) @(negedge busIf);
    dreq = 4'b0000;
    endTest();

    startTest("transfer");
    for (int c = 1; c < numChan; c++) begin
      setMask(chanT'(c), 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
      ai = k[1];
      dec = k[0];
      ty = (k[0] ^ k[1]) ? xferRead : xferWrite;
      rndState = xorshift(rndState);
      programChan(2'd0, rndState[15:0], 16'd3);
      setMode(2'd0, ty, ai, dec);
      readStatus();
      setMask(2'd0, 1'b0);
      dreq = 4'b0001;
      waitXfers(4);
      // without auto-init the channel must now stay masked
      if (!ai) begin
        repeat (10) @(negedge busIf);
      end
      dreq = 4'b0000;
      waitIdle();
      readStatus();
      if (ai) begin
        readWord(4'd0, word);
        checkVal("reload address", mBaseA[0], word);
      end
    end
    endTest();

    startTest("rotate");
    setCommand(8'h10);
    for (int c = 0; c < numChan; c++) begin
      programChan(chanT'(c), 16'h4000 + 16'h100 * c, 16'd50);
      setMode(chanT'(c), xferWrite, 1'b0, 1'b0);
      setMask(chanT'(c), 1'b0);
    end
    servedQ.delete();
    dreq = 4'b1111;
    waitXfers(5);
    dreq = 4'b0000;
    waitIdle();
    for (int i = 0; i < 5; i++) begin
      checkVal("dack order", 4'b0001 << (i % numChan), servedQ[i]);
    end
    endTest();

    startTest("eop");
    setCommand(8'h00);
    for (int c = 0; c < numChan; c++) begin
      setMask(chanT'(c), c != 2);
    end
    rndState = xorshift(rndState);
    abortAddr = rndState[15:0];
    programChan(2'd2, abortAddr, 16'd10);
    readStatus();
    dreq = 4'b0100;
    @(negedge busIf);
    while (!adstb) begin
      @(negedge busIf);
    end
    // abort in S1
    eopN = 1'b0;
    @(negedge busIf);
    eopN = 1'b1;
    while (!adstb) begin
      @(negedge busIf);
    end
    checkVal("repeat address", abortAddr, addrOut);
    waitXfers(1);
    dreq = 4'b0000;
    waitIdle();
    readStatus();
    endTest();

    $display("tests run %0d, errors %0d", testsRun, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/dmaPkg.sv
verilog/dmaCpuPort.sv
verilog/dmaChannelRegs.sv
verilog/dmaPriority.sv
verilog/dmaTiming.sv
verilog/dmaTop.sv
verification/dmaTb.sv
